// ==== common/dbg_pkg.sv ====
package dbg_pkg;

    // ==============================
    // Widths
    // ==============================
    typedef logic [6:0]  dmi_addr_t;
    typedef logic [31:0] dmi_data_t;
    typedef logic [1:0]  dmi_op_t;
    typedef logic [4:0]  ir_t;

    // Standard JTAG TAP states
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'h0,
        RUN_TEST_IDLE    = 4'h1,
        SELECT_DR_SCAN   = 4'h2,
        SELECT_IR_SCAN   = 4'h3,
        CAPTURE_DR       = 4'h4,
        CAPTURE_IR       = 4'h5,
        SHIFT_DR         = 4'h6,
        SHIFT_IR         = 4'h7,
        EXIT1_DR         = 4'h8,
        EXIT1_IR         = 4'h9,
        PAUSE_DR         = 4'hA,
        PAUSE_IR         = 4'hB,
        EXIT2_DR         = 4'hC,
        EXIT2_IR         = 4'hD,
        UPDATE_DR        = 4'hE,
        UPDATE_IR        = 4'hF
    } tap_state_t;

    // ==============================
    // Codes and constants
    // ==============================
    localparam dmi_op_t OP_NOP   = 2'd0;
    localparam dmi_op_t OP_READ  = 2'd1;
    localparam dmi_op_t OP_WRITE = 2'd2;

    localparam ir_t IR_BYPASS = 5'h00;
    localparam ir_t IR_IDCODE = 5'h01;
    localparam ir_t IR_DTMCS  = 5'h10;
    localparam ir_t IR_DMI    = 5'h11;

    localparam int IR_LEN  = 5;
    localparam int DMI_LEN = 41;    // addr + data + op

    localparam dmi_data_t IDCODE_VALUE = 32'h0053_7291;
    localparam dmi_data_t DTMCS_VALUE  = {22'd0, 6'd7, 4'd1};   // abits 7, version 1

    localparam dmi_addr_t DMSTATUS_ADDR  = 7'h11;
    localparam dmi_data_t DMSTATUS_VALUE = 32'h0000_0C82;
    localparam dmi_addr_t DATA_BASE_ADDR = 7'h04;
    localparam int        NUM_DATA_REGS  = 8;

    localparam int DMI_CREDITS = 2;     // Request queue depth in the DM

endpackage

// ==== hdl/jtag_sync.sv ====
`timescale 1ns/10ps

module jtag_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_ns,
    input  logic tms_ns,
    input  logic tdi_ns,
    output logic tck_rise,
    output logic tck_fall,
    output logic tms_s,
    output logic tdi_s
);

    logic [2:0] tck_q;
    logic [2:0] tms_q;
    logic [2:0] tdi_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tck_q <= 3'b000;
            tms_q <= 3'b000;
            tdi_q <= 3'b000;
        end else begin
            tck_q <= {tck_q[1:0], tck_ns};
            tms_q <= {tms_q[1:0], tms_ns};
            tdi_q <= {tdi_q[1:0], tdi_ns};
        end
    end

    // Edge seen between the last two stages
    assign tck_rise = !tck_q[2] && tck_q[1];
    assign tck_fall = tck_q[2] && !tck_q[1];

    // Pins settle long before tck moves
    assign tms_s = tms_q[2];
    assign tdi_s = tdi_q[2];

endmodule

// ==== dtm/dtm_tap.sv ====
`timescale 1ns/10ps

module dtm_tap import dbg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tck_rise,
    input  logic               tck_fall,
    input  logic               tms_s,
    input  logic               tdi_s,
    output logic               tdo,
    output logic               dmi_update,
    output logic [DMI_LEN-1:0] dmi_shift_in,
    input  logic [DMI_LEN-1:0] dmi_capture_word
);

    tap_state_t         state;
    tap_state_t         state_next;
    ir_t                ir;
    logic [DMI_LEN-1:0] sr;         // Data sits in the top sr_len bits
    logic [5:0]         sr_len;
    logic [5:0]         tdo_idx;
    logic [DMI_LEN-1:0] cap_word;
    logic [5:0]         cap_len;
    logic               tdo_q;
    logic               tdo_en;

    // ==============================
    // TAP state machine
    // ==============================
    always_comb begin
        case (state)
            TEST_LOGIC_RESET: state_next = tms_s ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_next = tms_s ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_next = tms_s ? SELECT_IR_SCAN   : CAPTURE_DR;
            SELECT_IR_SCAN:   state_next = tms_s ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_DR:       state_next = tms_s ? EXIT1_DR         : SHIFT_DR;
            CAPTURE_IR:       state_next = tms_s ? EXIT1_IR         : SHIFT_IR;
            SHIFT_DR:         state_next = tms_s ? EXIT1_DR         : SHIFT_DR;
            SHIFT_IR:         state_next = tms_s ? EXIT1_IR         : SHIFT_IR;
            EXIT1_DR:         state_next = tms_s ? UPDATE_DR        : PAUSE_DR;
            EXIT1_IR:         state_next = tms_s ? UPDATE_IR        : PAUSE_IR;
            PAUSE_DR:         state_next = tms_s ? EXIT2_DR         : PAUSE_DR;
            PAUSE_IR:         state_next = tms_s ? EXIT2_IR         : PAUSE_IR;
            EXIT2_DR:         state_next = tms_s ? UPDATE_DR        : SHIFT_DR;
            EXIT2_IR:         state_next = tms_s ? UPDATE_IR        : SHIFT_IR;
            UPDATE_DR:        state_next = tms_s ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            UPDATE_IR:        state_next = tms_s ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_next = TEST_LOGIC_RESET;
        endcase
    end

    // Capture value per instruction
    always_comb begin
        case (ir)
            IR_IDCODE: begin
                cap_word = {IDCODE_VALUE, {(DMI_LEN - 32){1'b0}}};
                cap_len  = 6'd32;
            end
            IR_DTMCS: begin
                cap_word = {DTMCS_VALUE, {(DMI_LEN - 32){1'b0}}};
                cap_len  = 6'd32;
            end
            IR_DMI: begin
                cap_word = dmi_capture_word;
                cap_len  = 6'(DMI_LEN);
            end
            default: begin                  // Bypass and unknown codes
                cap_word = '0;
                cap_len  = 6'd1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= TEST_LOGIC_RESET;
            ir     <= IR_IDCODE;
            sr_len <= 6'd1;
            tdo_q  <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            if (tck_rise) begin
                state <= state_next;
                if (state == CAPTURE_DR) begin
                    sr_len <= cap_len;
                end else if (state == CAPTURE_IR) begin
                    sr_len <= 6'(IR_LEN);
                end
            end
            if (tck_fall) begin
                tdo_q  <= sr[tdo_idx];
                tdo_en <= (state == SHIFT_DR) || (state == SHIFT_IR);
            end
            if (state == TEST_LOGIC_RESET) begin
                ir <= IR_IDCODE;
            end else if (tck_fall && state == UPDATE_IR) begin
                ir <= sr[DMI_LEN-1 -: IR_LEN];
            end
        end
    end

    // ==============================
    // Shift register
    // ==============================
    always_ff @(posedge clk) begin
        if (tck_rise) begin
            case (state)
                CAPTURE_DR: sr <= cap_word;
                CAPTURE_IR: sr <= {ir_t'(1), {(DMI_LEN - IR_LEN){1'b0}}};
                SHIFT_DR,
                SHIFT_IR:   sr <= {tdi_s, sr[DMI_LEN-1:1]};     // In at top, out at bottom
                default: ;
            endcase
        end
    end

    assign tdo_idx = 6'(DMI_LEN) - sr_len;
    assign tdo     = tdo_q && tdo_en;

    assign dmi_update   = tck_fall && (state == UPDATE_DR) && (ir == IR_DMI);
    assign dmi_shift_in = sr;

    a_state_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state));

endmodule

// ==== dtm/dmi_request.sv ====
`timescale 1ns/10ps

module dmi_request import dbg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dmi_update,
    input  logic [DMI_LEN-1:0] dmi_shift_in,
    output logic [DMI_LEN-1:0] dmi_capture_word,
    output logic               req_valid,
    output dmi_addr_t          req_addr,
    output dmi_data_t          req_data,
    output dmi_op_t            req_op,
    input  logic               credit_return,
    input  logic               rsp_valid,
    input  dmi_data_t          rsp_data
);

    logic [DMI_LEN-1:0] dmi_reg;
    dmi_addr_t          cur_addr;
    dmi_data_t          cur_data;
    dmi_op_t            cur_op;
    dmi_op_t            upd_op;
    logic               upd_access;
    logic               busy;           // Update seen, no response yet
    logic               req_pend;       // Waiting for a credit
    logic [1:0]         credits;

    assign cur_addr = dmi_reg[40:34];
    assign cur_data = dmi_reg[33:2];
    assign cur_op   = dmi_reg[1:0];

    assign upd_op     = dmi_shift_in[1:0];
    assign upd_access = dmi_update && (upd_op == OP_READ || upd_op == OP_WRITE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmi_reg  <= '0;
            busy     <= 1'b0;
            req_pend <= 1'b0;
        end else begin
            if (upd_access) begin
                dmi_reg  <= dmi_shift_in;
                busy     <= 1'b1;
                req_pend <= 1'b1;
            end else if (dmi_update) begin
                dmi_reg[1:0] <= OP_NOP;     // Keep addr and data
            end
            if (req_valid) begin
                req_pend <= 1'b0;
            end
            if (rsp_valid) begin
                busy         <= 1'b0;
                dmi_reg[1:0] <= OP_NOP;
                if (cur_op == OP_READ) begin
                    dmi_reg[33:2] <= rsp_data;
                end
            end
        end
    end

    // ==============================
    // Credit counter
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= 2'(DMI_CREDITS);
        end else begin
            case ({req_valid, credit_return})
                2'b10:   credits <= credits - 2'd1;
                2'b01:   credits <= credits + 2'd1;
                default: ;
            endcase
        end
    end

    assign req_valid = req_pend && (credits != 2'd0);
    assign req_addr  = cur_addr;
    assign req_data  = cur_data;
    assign req_op    = cur_op;

    // Op reads back 3 while the access is in flight
    assign dmi_capture_word = {cur_addr, cur_data, busy ? dmi_op_t'(3) : cur_op};

    a_rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> busy && !req_pend);

    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= 2'(DMI_CREDITS));

endmodule

// ==== dm/dm_regs.sv ====
`timescale 1ns/10ps

module dm_regs import dbg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  dmi_addr_t req_addr,
    input  dmi_data_t req_data,
    input  dmi_op_t   req_op,
    output logic      credit_return,
    output logic      rsp_valid,
    output dmi_data_t rsp_data
);

    // ==============================
    // Request queue
    // ==============================
    dmi_addr_t q_addr [DMI_CREDITS];
    dmi_data_t q_data [DMI_CREDITS];
    dmi_op_t   q_op   [DMI_CREDITS];

    logic [$clog2(DMI_CREDITS)-1:0]   wr_ptr;
    logic [$clog2(DMI_CREDITS)-1:0]   rd_ptr;
    logic [$clog2(DMI_CREDITS+1)-1:0] count;
    logic                             retire;

    dmi_data_t                        data_regs [NUM_DATA_REGS];
    dmi_addr_t                        head_addr;
    dmi_op_t                          head_op;
    logic                             head_is_data;
    logic [$clog2(NUM_DATA_REGS)-1:0] head_idx;

    assign retire = (count != '0);  // One entry per cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_addr[wr_ptr] <= req_addr;
            q_data[wr_ptr] <= req_data;
            q_op[wr_ptr]   <= req_op;
        end
    end

    // ==============================
    // Register bank
    // ==============================
    assign head_addr    = q_addr[rd_ptr];
    assign head_op      = q_op[rd_ptr];
    assign head_is_data = (head_addr >= DATA_BASE_ADDR) &&
                          (head_addr < DATA_BASE_ADDR + NUM_DATA_REGS);
    assign head_idx     = $clog2(NUM_DATA_REGS)'(head_addr - DATA_BASE_ADDR);

    always_ff @(posedge clk) begin
        if (retire && head_op == OP_WRITE && head_is_data) begin
            data_regs[head_idx] <= q_data[rd_ptr];
        end
    end

    always_comb begin
        rsp_data = '0;                      // Writes and unmapped reads
        if (head_op == OP_READ) begin
            if (head_is_data) begin
                rsp_data = data_regs[head_idx];
            end else if (head_addr == DMSTATUS_ADDR) begin
                rsp_data = DMSTATUS_VALUE;
            end
        end
    end

    assign rsp_valid     = retire;
    assign credit_return = retire;         // One credit per retired entry

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> count < DMI_CREDITS);

endmodule

// ==== hdl/debug_top.sv ====
`timescale 1ns/10ps

module debug_top import dbg_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_ns,
    input  logic tms_ns,
    input  logic tdi_ns,
    output logic tdo
);

    logic               tck_rise;
    logic               tck_fall;
    logic               tms_s;
    logic               tdi_s;

    logic               dmi_update;
    logic [DMI_LEN-1:0] dmi_shift_in;
    logic [DMI_LEN-1:0] dmi_capture_word;

    // DMI link
    logic               req_valid;
    dmi_addr_t          req_addr;
    dmi_data_t          req_data;
    dmi_op_t            req_op;
    logic               credit_return;
    logic               rsp_valid;
    dmi_data_t          rsp_data;

    jtag_sync u_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck_ns   (tck_ns),
        .tms_ns   (tms_ns),
        .tdi_ns   (tdi_ns),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall),
        .tms_s    (tms_s),
        .tdi_s    (tdi_s)
    );

    dtm_tap u_tap (
        .clk              (clk),
        .rst_n            (rst_n),
        .tck_rise         (tck_rise),
        .tck_fall         (tck_fall),
        .tms_s            (tms_s),
        .tdi_s            (tdi_s),
        .tdo              (tdo),
        .dmi_update       (dmi_update),
        .dmi_shift_in     (dmi_shift_in),
        .dmi_capture_word (dmi_capture_word)
    );

    dmi_request u_req (
        .clk              (clk),
        .rst_n            (rst_n),
        .dmi_update       (dmi_update),
        .dmi_shift_in     (dmi_shift_in),
        .dmi_capture_word (dmi_capture_word),
        .req_valid        (req_valid),
        .req_addr         (req_addr),
        .req_data         (req_data),
        .req_op           (req_op),
        .credit_return    (credit_return),
        .rsp_valid        (rsp_valid),
        .rsp_data         (rsp_data)
    );

    dm_regs u_dm (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .req_op        (req_op),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data)
    );

endmodule

// ==== sim/scan_checker.sv ====
`timescale 1ns/10ps

module scan_checker import dbg_pkg::*; (
    input  logic        rst_n,
    input  logic        tck_ns,
    input  logic        tms_ns,
    input  logic        tdo,
    input  logic [63:0] exp_word,
    input  logic [6:0]  exp_len,
    input  logic        exp_en,
    output int          error_count,
    output int          scan_count
);

    tap_state_t  state = TEST_LOGIC_RESET;
    tap_state_t  state_after;
    logic [63:0] got;
    int          bit_idx;

    // IEEE 1149.1 state diagram, followed from the tms pin
    function automatic tap_state_t tap_next(input tap_state_t s, input logic tms);
        case (s)
            TEST_LOGIC_RESET: return tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   return tms ? SELECT_IR_SCAN : CAPTURE_DR;
            SELECT_IR_SCAN:   return tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_DR,
            SHIFT_DR:         return tms ? EXIT1_DR : SHIFT_DR;
            CAPTURE_IR,
            SHIFT_IR:         return tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_DR:         return tms ? UPDATE_DR : PAUSE_DR;
            EXIT1_IR:         return tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_DR:         return tms ? EXIT2_DR : PAUSE_DR;
            PAUSE_IR:         return tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_DR:         return tms ? UPDATE_DR : SHIFT_DR;
            EXIT2_IR:         return tms ? UPDATE_IR : SHIFT_IR;
            default:          return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;  // Both Update states
        endcase
    endfunction

    // Exit2 into Shift is never used by the testbench, so a capture starts each word
    task automatic check_word();
        logic [63:0] mask;
        mask = (64'd1 << exp_len) - 64'd1;
        scan_count++;
        if (exp_en) begin
            if (bit_idx != int'(exp_len)) begin
                $display("Scan %0d shifted %0d bits where %0d were expected",
                         scan_count, bit_idx, exp_len);
                error_count++;
            end else if ((got & mask) !== (exp_word & mask)) begin
                $display("ERROR at %0t: tdo word expected 0x%h, got 0x%h",
                         $time, exp_word & mask, got & mask);
                error_count++;
            end
        end
    endtask

    initial begin
        error_count = 0;
        scan_count  = 0;
        got         = '0;
        bit_idx     = 0;
    end

    always @(posedge tck_ns) begin
        state_after = tap_next(state, tms_ns);
        if (!rst_n) begin
            state <= TEST_LOGIC_RESET;
        end else begin
            if (state == CAPTURE_DR) begin
                got     = '0;
                bit_idx = 0;
            end
            if (state == SHIFT_DR) begin
                if (bit_idx < 64) begin
                    got[bit_idx] = tdo;     // LSB first
                end
                bit_idx++;
            end
            if (state == SHIFT_DR && state_after == EXIT1_DR) begin
                check_word();
            end
            state <= state_after;
        end
    end

endmodule

// ==== sim/tb_debug_top.sv ====
`timescale 1ns/10ps

module tb_debug_top import dbg_pkg::*; ();

    localparam int TCK_HALF     = 4;    // clk cycles per tck phase
    localparam int SCAN_TIMEOUT = 200;

    logic        clk;
    logic        rst_n;
    logic        tck_ns;
    logic        tms_ns;
    logic        tdi_ns;
    wire         tdo;

    logic [63:0] exp_word;
    logic [6:0]  exp_len;
    logic        exp_en;
    int          chk_errors;
    int          scans_seen;
    int          scans_sent;
    int          timeouts;
    int          idx;
    int unsigned seed_val;
    ir_t         cur_ir;
    logic [40:0] dmi_model;             // What the next DMI capture should show
    dmi_data_t   rnd_data;

    // ==============================
    // Scan table
    // ==============================
    ir_t         tbl_ir  [$];
    logic        tbl_tlr [$];           // Walk through Test-Logic-Reset first
    int          tbl_len [$];
    logic [63:0] tbl_in  [$];
    logic [63:0] tbl_exp [$];
    logic        tbl_chk [$];

    debug_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .tck_ns (tck_ns),
        .tms_ns (tms_ns),
        .tdi_ns (tdi_ns),
        .tdo    (tdo)
    );

    scan_checker u_scan_chk (
        .rst_n       (rst_n),
        .tck_ns      (tck_ns),
        .tms_ns      (tms_ns),
        .tdo         (tdo),
        .exp_word    (exp_word),
        .exp_len     (exp_len),
        .exp_en      (exp_en),
        .error_count (chk_errors),
        .scan_count  (scans_seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [63:0] dmi_word(input dmi_addr_t a, input dmi_data_t d,
                                             input dmi_op_t op);
        return {23'd0, a, d, op};
    endfunction

    // Bypass is one flop deep
    function automatic logic [63:0] bypass_expect(input logic [63:0] pattern, input int n);
        return (pattern << 1) & ((64'd1 << n) - 64'd1);
    endfunction

    task automatic add_scan(input ir_t ir, input logic tlr, input int len,
                            input logic [63:0] din, input logic [63:0] dexp,
                            input logic chk);
        tbl_ir.push_back(ir);
        tbl_tlr.push_back(tlr);
        tbl_len.push_back(len);
        tbl_in.push_back(din);
        tbl_exp.push_back(dexp);
        tbl_chk.push_back(chk);
    endtask

    // next_data is the data field once the access has completed
    task automatic add_dmi(input dmi_addr_t a, input dmi_data_t d, input dmi_op_t op,
                           input dmi_data_t next_data);
        add_scan(IR_DMI, 1'b0, DMI_LEN, dmi_word(a, d, op), {23'd0, dmi_model}, 1'b1);
        if (op != OP_NOP) begin
            dmi_model = {a, next_data, OP_NOP};
        end
    endtask

    task automatic build_table();
        dmi_addr_t addr;
        int        i;
        add_scan(IR_IDCODE, 1'b0, 32, 64'd0, {32'd0, IDCODE_VALUE}, 1'b1);
        add_scan(IR_BYPASS, 1'b0, 16, 64'hB38D, bypass_expect(64'hB38D, 16), 1'b1);
        add_scan(IR_BYPASS, 1'b0, 9, 64'h1A5, bypass_expect(64'h1A5, 9), 1'b1);
        add_scan(IR_DTMCS, 1'b0, 32, 64'd0, {32'd0, DTMCS_VALUE}, 1'b1);
        for (i = 0; i < NUM_DATA_REGS; i++) begin
            addr     = DATA_BASE_ADDR + 7'(i);
            rnd_data = $urandom();
            add_dmi(addr, rnd_data, OP_WRITE, rnd_data);
            add_dmi(addr, ~rnd_data, OP_READ, rnd_data);    // Junk data in, bank data out
            add_dmi(7'd0, 32'd0, OP_NOP, 32'd0);
        end
        add_dmi(DMSTATUS_ADDR, 32'd0, OP_READ, DMSTATUS_VALUE);
        add_dmi(7'd0, 32'd0, OP_NOP, 32'd0);
        rnd_data = $urandom();
        add_dmi(7'h30, rnd_data, OP_WRITE, rnd_data);       // Unmapped
        add_dmi(7'h30, ~rnd_data, OP_READ, 32'd0);
        add_dmi(7'd0, 32'd0, OP_NOP, 32'd0);
        add_scan(IR_BYPASS, 1'b0, 8, 64'h6B, bypass_expect(64'h6B, 8), 1'b1);
        add_scan(IR_IDCODE, 1'b1, 32, 64'd0, {32'd0, IDCODE_VALUE}, 1'b1);
    endtask

    // ==============================
    // JTAG pin wiggling
    // ==============================
    task automatic tck_cycle(input logic tms, input logic tdi);
        @(negedge clk);
        tck_ns <= 1'b0;
        tms_ns <= tms;
        tdi_ns <= tdi;
        repeat (TCK_HALF) @(negedge clk);
        tck_ns <= 1'b1;
        repeat (TCK_HALF - 1) @(negedge clk);
    endtask

    task automatic ir_scan(input ir_t code);
        int i;
        tck_cycle(1'b0, 1'b0);      // Run-Test/Idle
        tck_cycle(1'b1, 1'b0);
        tck_cycle(1'b1, 1'b0);
        tck_cycle(1'b0, 1'b0);      // Capture-IR
        tck_cycle(1'b0, 1'b0);
        for (i = 0; i < IR_LEN; i++) begin
            tck_cycle(i == IR_LEN - 1, code[i]);
        end
        tck_cycle(1'b1, 1'b0);      // Update-IR
        tck_cycle(1'b0, 1'b0);
    endtask

    task automatic dr_scan(input int len, input logic [63:0] din);
        int i;
        tck_cycle(1'b0, 1'b0);
        tck_cycle(1'b1, 1'b0);
        tck_cycle(1'b0, 1'b0);      // Capture-DR
        tck_cycle(1'b0, 1'b0);
        for (i = 0; i < len; i++) begin
            tck_cycle(i == len - 1, din[i]);
        end
        tck_cycle(1'b1, 1'b0);      // Update-DR
        tck_cycle(1'b0, 1'b0);
    endtask

    task automatic tap_reset();
        repeat (5) tck_cycle(1'b1, 1'b0);
    endtask

    task automatic wait_checker(input int target);
        int cycles;
        cycles = 0;
        while (scans_seen < target && cycles < SCAN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (scans_seen < target) begin
            $display("Timeout: the checker never finished DR scan %0d", target);
            timeouts++;
        end
    endtask

    initial begin
        tck_ns     = 1'b0;
        tms_ns     = 1'b0;
        tdi_ns     = 1'b0;
        rst_n      = 1'b0;
        exp_word   = '0;
        exp_len    = '0;
        exp_en     = 1'b0;
        timeouts   = 0;
        scans_sent = 0;
        cur_ir     = IR_IDCODE;
        dmi_model  = '0;
        seed_val   = $urandom(34222);
        build_table();
        repeat (3) @(negedge clk);
        rst_n <= 1'b1;

        for (idx = 0; idx < tbl_ir.size(); idx++) begin
            if (tbl_tlr[idx]) begin
                tap_reset();
                cur_ir = IR_IDCODE;
            end
            if (tbl_ir[idx] != cur_ir) begin
                ir_scan(tbl_ir[idx]);
                cur_ir = tbl_ir[idx];
            end
            exp_word <= tbl_exp[idx];
            exp_len  <= 7'(tbl_len[idx]);
            exp_en   <= tbl_chk[idx];
            dr_scan(tbl_len[idx], tbl_in[idx]);
            scans_sent++;
            wait_checker(scans_sent);
        end

        $display("DR scans: %0d, checker errors: %0d, timeouts: %0d",
                 scans_seen, chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== debug_top.f ====
common/dbg_pkg.sv
hdl/jtag_sync.sv
dtm/dtm_tap.sv
dtm/dmi_request.sv
dm/dm_regs.sv
hdl/debug_top.sv
sim/scan_checker.sv
sim/tb_debug_top.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; status follows the testbench verdict
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f debug_top.f \
        --top-module tb_debug_top -o tb_debug_top \
    && ./obj_dir/tb_debug_top | tee /dev/stderr | grep -q "Verification passed" \
    && exit 0 \
    || exit 1
